/* routerOutput.f */
source/nocPkg.sv
source/inputFifo.sv
source/flitTimer.sv
source/portArbiter.sv
source/outputSwitch.sv
source/routerOutput.sv
tb/routerOutputTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --top-module routerOutputTb -f routerOutput.f -o routerOutputSim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/routerOutputSim > "$LOG" 2>&1 || { cat "$LOG"; echo "Simulation exited with an error"; exit 1; }
cat "$LOG"
grep -q "Result: FAILED" "$LOG" && exit 1 || exit 0

/* source/flitTimer.sv */
`default_nettype none

module flitTimer (
  input  logic                           clk,
  input  logic                           rst,
  input  nocPkg::FlitIdT                 headFlitId,
  input  logic [nocPkg::LengthWidth-1:0] headLength,
  input  logic                           runTimer,
  output logic                           timesUp
);

  logic [nocPkg::LengthWidth-1:0] period;
  logic [nocPkg::LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      period <= '0;
      count  <= '0;
    end
    else
    begin
      if (headFlitId == nocPkg::FlitHeader)
        period <= headLength; // Reload on any header at the head.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0; // Restart for the next grant.
    end
  end

  // Expires once a full packet has been granted.
  assign timesUp = (count == period);

endmodule

`default_nettype wire

/* source/inputFifo.sv */
`default_nettype none

module inputFifo #(
  parameter int FlitWidth = 16,
  parameter int FifoDepth = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  logic [FlitWidth-1:0] pushData,
  input  nocPkg::FlitIdT       pushFlitId,
  input  logic                 pop,
  output logic                 full,
  output logic                 nonEmpty,
  output logic [FlitWidth-1:0] headData,
  output nocPkg::FlitIdT       headFlitId
);

  localparam int PtrWidth = $clog2(FifoDepth);

  logic [FlitWidth-1:0] dataMem [FifoDepth];
  nocPkg::FlitIdT       idMem [FifoDepth];
  logic [PtrWidth-1:0]  wrPtr;
  logic [PtrWidth-1:0]  rdPtr;
  logic [PtrWidth:0]    count;
  logic                 doPush;
  logic                 doPop;

  assign full     = (count == FifoDepth[PtrWidth:0]);
  assign nonEmpty = (count != '0);
  assign doPush   = push && !full; // Write while full is lost.
  assign doPop    = pop && nonEmpty;

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      dataMem[wrPtr] <= pushData;
      idMem[wrPtr]   <= pushFlitId;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1; // Wraps, depth is a power of two.
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

  // Head is read straight from memory.
  assign headData   = dataMem[rdPtr];
  assign headFlitId = idMem[rdPtr];

endmodule

`default_nettype wire

/* source/nocPkg.sv */
`default_nettype none

package nocPkg;

  localparam int NumPorts = 5; // Local, North, East, West, South.
  localparam int PortIdxWidth = $clog2(NumPorts);

  // Header flits carry the packet length in the low payload bits.
  localparam int LengthWidth = 12;

  typedef enum logic [2:0] {
    FlitHeader = 3'b001,
    FlitBody   = 3'b010,
    FlitTail   = 3'b100
  } FlitIdT;

  // Bit 0 is Idle, bit p+1 is the grant to port p.
  typedef enum logic [5:0] {
    ArbIdle  = 6'b000001,
    ArbLocal = 6'b000010,
    ArbNorth = 6'b000100,
    ArbEast  = 6'b001000,
    ArbWest  = 6'b010000,
    ArbSouth = 6'b100000
  } ArbStateT;

  // Source tag on the output, also the rotation order.
  typedef enum logic [2:0] {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortWest  = 3'd3,
    PortSouth = 3'd4
  } PortT;

endpackage

`default_nettype wire

/* source/outputSwitch.sv */
`default_nettype none

module outputSwitch #(
  parameter int FlitWidth = 16
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [nocPkg::NumPorts-1:0]              pop,
  input  logic [nocPkg::NumPorts-1:0][FlitWidth-1:0] headData,
  input  nocPkg::FlitIdT [nocPkg::NumPorts-1:0]    headFlitId,
  output logic                                     outValid,
  output logic [FlitWidth-1:0]                     outData,
  output nocPkg::FlitIdT                           outFlitId,
  output nocPkg::PortT                             outPort
);

  logic                 anyPop;
  logic [FlitWidth-1:0] selData;
  nocPkg::FlitIdT       selFlitId;
  nocPkg::PortT         selPort;

  assign anyPop = |pop;

  // Pop is one-hot, so at most one port matches.
  always_comb
  begin
    selData   = '0;
    selFlitId = nocPkg::FlitBody;
    selPort   = nocPkg::PortLocal;
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      if (pop[p])
      begin
        selData   = headData[p];
        selFlitId = headFlitId[p];
        selPort   = nocPkg::PortT'(p[nocPkg::PortIdxWidth-1:0]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= anyPop;
  end

  always_ff @(posedge clk)
  begin
    if (anyPop)
    begin
      outData   <= selData;
      outFlitId <= selFlitId;
      outPort   <= selPort; // Source tag for the downstream hop.
    end
  end

endmodule

`default_nettype wire

/* source/portArbiter.sv */
`default_nettype none

module portArbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [nocPkg::NumPorts-1:0]                          req,
  input  nocPkg::FlitIdT [nocPkg::NumPorts-1:0]                headFlitId,
  input  logic [nocPkg::NumPorts-1:0][nocPkg::LengthWidth-1:0] headLength,
  output logic [nocPkg::NumPorts-1:0]                          pop
);

  nocPkg::ArbStateT                curState;
  nocPkg::ArbStateT                nextState;
  logic [nocPkg::NumPorts-1:0]     timesUp;
  logic [nocPkg::PortIdxWidth-1:0] curPort;
  logic                            inPort;

  // Grant state for port idx.
  function automatic nocPkg::ArbStateT portState(input int unsigned idx);
    logic [$bits(nocPkg::ArbStateT)-1:0] oneHot;
    oneHot = 6'b000010 << idx;
    return nocPkg::ArbStateT'(oneHot);
  endfunction

  // First requester after port last in rotation order.
  // The last port itself is only considered when allowLast is set.
  function automatic nocPkg::ArbStateT scanNext(
    input logic [nocPkg::NumPorts-1:0]     reqs,
    input logic [nocPkg::PortIdxWidth-1:0] last,
    input logic                            allowLast
  );
    nocPkg::ArbStateT found;
    int unsigned      idx;
    found = nocPkg::ArbIdle;
    for (int i = nocPkg::NumPorts; i >= 1; i--)
    begin
      idx = last + i;
      if (idx >= nocPkg::NumPorts)
        idx = idx - nocPkg::NumPorts;
      if (reqs[idx] && (allowLast || (i < nocPkg::NumPorts)))
        found = portState(idx); // Nearest one wins.
    end
    return found;
  endfunction

  for (genvar p = 0; p < nocPkg::NumPorts; p++)
  begin : gTimer
    flitTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .headFlitId (headFlitId[p]),
      .headLength (headLength[p]),
      .runTimer   (pop[p]),
      .timesUp    (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      curState <= nocPkg::ArbIdle;
    else
      curState <= nextState;
  end

  // Idle behaves as if South was the last grant, so the scan starts at Local.
  always_comb
  begin
    curPort = nocPkg::PortSouth;
    inPort  = 1'b0;
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      if (curState[p + 1])
      begin
        curPort = p[nocPkg::PortIdxWidth-1:0];
        inPort  = 1'b1;
      end
    end
  end

  always_comb
  begin
    pop       = '0;
    nextState = scanNext(req, curPort, !inPort);
    if (inPort && req[curPort] && !timesUp[curPort])
    begin
      pop[curPort] = 1'b1; // Also runs that port's timer.
      nextState    = curState;
    end
  end

endmodule

`default_nettype wire

/* source/routerOutput.sv */
`default_nettype none

module routerOutput #(
  parameter int FlitWidth = 16,
  parameter int FifoDepth = 8
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [nocPkg::NumPorts-1:0]                inValid,
  input  logic [nocPkg::NumPorts-1:0][FlitWidth-1:0] inData,
  input  nocPkg::FlitIdT [nocPkg::NumPorts-1:0]      inFlitId,
  output logic [nocPkg::NumPorts-1:0]                inFull,
  output logic                                       outValid,
  output logic [FlitWidth-1:0]                       outData,
  output nocPkg::FlitIdT                             outFlitId,
  output nocPkg::PortT                               outPort
);

  logic [nocPkg::NumPorts-1:0]                          req;
  logic [nocPkg::NumPorts-1:0]                          pop;
  logic [nocPkg::NumPorts-1:0][FlitWidth-1:0]           headData;
  nocPkg::FlitIdT [nocPkg::NumPorts-1:0]                headFlitId;
  logic [nocPkg::NumPorts-1:0][nocPkg::LengthWidth-1:0] headLength;

  for (genvar p = 0; p < nocPkg::NumPorts; p++)
  begin : gPort
    inputFifo #(
      .FlitWidth (FlitWidth),
      .FifoDepth (FifoDepth)
    ) uFifo (
      .clk        (clk),
      .rst        (rst),
      .push       (inValid[p]),
      .pushData   (inData[p]),
      .pushFlitId (inFlitId[p]),
      .pop        (pop[p]),
      .full       (inFull[p]),
      .nonEmpty   (req[p]),
      .headData   (headData[p]),
      .headFlitId (headFlitId[p])
    );

    // Length field of a header flit.
    assign headLength[p] = headData[p][nocPkg::LengthWidth-1:0];
  end

  portArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .headFlitId (headFlitId),
    .headLength (headLength),
    .pop        (pop)
  );

  outputSwitch #(
    .FlitWidth (FlitWidth)
  ) uSwitch (
    .clk        (clk),
    .rst        (rst),
    .pop        (pop),
    .headData   (headData),
    .headFlitId (headFlitId),
    .outValid   (outValid),
    .outData    (outData),
    .outFlitId  (outFlitId),
    .outPort    (outPort)
  );

endmodule

`default_nettype wire

/* tb/routerOutputTb.sv */
`default_nettype none

module routerOutputTb;

  localparam int FlitWidth   = 16;
  localparam int FifoDepth   = 8;
  localparam int NumPorts    = nocPkg::NumPorts;
  localparam int MaxFlits    = 64;
  localparam int WaitLimit   = 400; // Cycles before an output wait gives up.
  localparam int QuietCycles = 12;

  logic                               clk;
  logic                               rst;
  logic [NumPorts-1:0]                inValid;
  logic [NumPorts-1:0][FlitWidth-1:0] inData;
  nocPkg::FlitIdT [NumPorts-1:0]      inFlitId;
  logic [NumPorts-1:0]                inFull;
  logic                               outValid;
  logic [FlitWidth-1:0]               outData;
  nocPkg::FlitIdT                     outFlitId;
  nocPkg::PortT                       outPort;

  integer seed;
  int     errorCount;

  // Packet lengths for the next send, zero leaves a port idle.
  int firstLen [NumPorts];
  int secondLen [NumPorts];

  logic [FlitWidth-1:0] sentData [NumPorts][MaxFlits];
  nocPkg::FlitIdT       sentId [NumPorts][MaxFlits];
  int                   sentCount [NumPorts];

  logic [FlitWidth-1:0] expData[$];
  nocPkg::FlitIdT       expId[$];
  nocPkg::PortT         expPort[$];

  logic [FlitWidth-1:0] gotData[$];
  nocPkg::FlitIdT       gotId[$];
  nocPkg::PortT         gotPort[$];
  int                   gotCycle[$];

  routerOutput #(
    .FlitWidth (FlitWidth),
    .FifoDepth (FifoDepth)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inData    (inData),
    .inFlitId  (inFlitId),
    .inFull    (inFull),
    .outValid  (outValid),
    .outData   (outData),
    .outFlitId (outFlitId),
    .outPort   (outPort)
  );

  always #2 clk = ~clk;

  task automatic clearTraffic();
    for (int p = 0; p < NumPorts; p++)
    begin
      firstLen[p]  = 0;
      secondLen[p] = 0;
      sentCount[p] = 0;
    end
    expData.delete();
    expId.delete();
    expPort.delete();
    gotData.delete();
    gotId.delete();
    gotPort.delete();
    gotCycle.delete();
  endtask

  function automatic int offeredFlits();
    int sum;
    sum = 0;
    for (int p = 0; p < NumPorts; p++)
      sum += firstLen[p] + secondLen[p];
    return sum;
  endfunction

  // One flit per port per cycle, second packet right behind the first.
  task automatic sendPackets();
    int                   total [NumPorts];
    int                   maxCycles;
    int                   pos;
    int                   len;
    logic [31:0]          randWord;
    logic [FlitWidth-1:0] payload;
    nocPkg::FlitIdT       kind;
    maxCycles = 0;
    for (int p = 0; p < NumPorts; p++)
    begin
      total[p] = firstLen[p] + secondLen[p];
      if (total[p] > maxCycles)
        maxCycles = total[p];
    end
    for (int c = 0; c < maxCycles; c++)
    begin
      @(negedge clk);
      for (int p = 0; p < NumPorts; p++)
      begin
        if (c < total[p])
        begin
          if (c < firstLen[p])
          begin
            pos = c;
            len = firstLen[p];
          end
          else
          begin
            pos = c - firstLen[p];
            len = secondLen[p];
          end
          randWord = $random(seed);
          payload  = randWord[FlitWidth-1:0];
          if (pos == 0)
          begin
            kind = nocPkg::FlitHeader;
            payload[nocPkg::LengthWidth-1:0] = len[nocPkg::LengthWidth-1:0]; // Length field.
          end
          else if (pos == len - 1)
            kind = nocPkg::FlitTail;
          else
            kind = nocPkg::FlitBody;
          inValid[p]  = 1'b1;
          inData[p]   = payload;
          inFlitId[p] = kind;
          sentData[p][sentCount[p]] = payload;
          sentId[p][sentCount[p]]   = kind;
          sentCount[p]++;
        end
        else
          inValid[p] = 1'b0;
      end
    end
    @(negedge clk);
    inValid = '0;
  endtask

  task automatic collectOutputs(input int expectedTotal);
    int cycle;
    int stray;
    cycle = 0;
    while (gotData.size() < expectedTotal && cycle < WaitLimit)
    begin
      @(negedge clk);
      cycle++;
      if (outValid)
      begin
        gotData.push_back(outData);
        gotId.push_back(outFlitId);
        gotPort.push_back(outPort);
        gotCycle.push_back(cycle);
      end
    end
    if (gotData.size() < expectedTotal)
    begin
      $display("Timed out after %0d cycles with %0d of %0d output flits",
               cycle, gotData.size(), expectedTotal);
      errorCount++;
    end
    stray = 0;
    for (int i = 0; i < QuietCycles; i++)
    begin
      @(negedge clk);
      if (outValid)
        stray++;
    end
    if (stray != 0)
    begin
      $display("Output sent %0d flits beyond the expected stream", stray);
      errorCount++;
    end
  endtask

  // Packets that start together leave in rotation order from Local.
  task automatic buildExpected();
    logic [NumPorts-1:0] pending;
    int                  last;
    int                  idx;
    int                  pick;
    pending = '0;
    for (int p = 0; p < NumPorts; p++)
      pending[p] = (sentCount[p] != 0);
    last = NumPorts - 1;
    while (pending != '0)
    begin
      pick = -1;
      for (int i = 1; i <= NumPorts; i++)
      begin
        idx = (last + i) % NumPorts;
        if (pick < 0 && pending[idx])
          pick = idx;
      end
      for (int k = 0; k < sentCount[pick]; k++)
      begin
        expData.push_back(sentData[pick][k]);
        expId.push_back(sentId[pick][k]);
        expPort.push_back(nocPkg::PortT'(pick[nocPkg::PortIdxWidth-1:0]));
      end
      pending[pick] = 1'b0;
      last = pick;
    end
  endtask

  task automatic compareStream();
    int n;
    n = (gotData.size() < expData.size()) ? gotData.size() : expData.size();
    if (gotData.size() != expData.size())
    begin
      $display("Output carried %0d flits where %0d were expected", gotData.size(), expData.size());
      errorCount++;
    end
    for (int i = 0; i < n; i++)
    begin
      if (gotPort[i] !== expPort[i])
      begin
        $display("ERROR outPort at flit %0d: expected 0x%0h, got 0x%0h", i, expPort[i], gotPort[i]);
        errorCount++;
      end
      if (gotId[i] !== expId[i])
      begin
        $display("ERROR outFlitId at flit %0d: expected 0x%0h, got 0x%0h", i, expId[i], gotId[i]);
        errorCount++;
      end
      if (gotData[i] !== expData[i])
      begin
        $display("ERROR outData at flit %0d: expected 0x%0h, got 0x%0h", i, expData[i], gotData[i]);
        errorCount++;
      end
      if (i > 0 && expId[i] != nocPkg::FlitHeader && gotCycle[i] - gotCycle[i - 1] != 1)
      begin
        $display("Packet broken by a gap before output flit %0d", i);
        errorCount++;
      end
    end
  endtask

  task automatic runTraffic();
    int total;
    total = offeredFlits();
    fork
      sendPackets();
      collectOutputs(total);
    join
    buildExpected();
    compareStream();
  endtask

  task automatic idleAfterReset();
    @(negedge clk);
    if (outValid !== 1'b0)
    begin
      $display("ERROR outValid: expected 0x0, got 0x%0h", outValid);
      errorCount++;
    end
    if (inFull !== '0)
    begin
      $display("ERROR inFull: expected 0x0, got 0x%0h", inFull);
      errorCount++;
    end
    for (int i = 0; i < 20; i++)
    begin
      @(negedge clk);
      if (outValid !== 1'b0)
      begin
        $display("ERROR outValid while inputs idle: expected 0x0, got 0x%0h", outValid);
        errorCount++;
      end
    end
  endtask

  task automatic singlePacket();
    clearTraffic();
    firstLen[nocPkg::PortEast] = 6;
    runTraffic();
  endtask

  task automatic twoPortContention();
    clearTraffic();
    firstLen[nocPkg::PortLocal] = 5;
    firstLen[nocPkg::PortSouth] = 4;
    runTraffic();
  endtask

  task automatic allPortRotation();
    clearTraffic();
    firstLen[nocPkg::PortLocal] = 3;
    firstLen[nocPkg::PortNorth] = 7;
    firstLen[nocPkg::PortEast]  = 2;
    firstLen[nocPkg::PortWest]  = 5;
    firstLen[nocPkg::PortSouth] = 4;
    runTraffic();
  endtask

  task automatic backToBackPackets();
    clearTraffic();
    firstLen[nocPkg::PortNorth]  = 3;
    secondLen[nocPkg::PortNorth] = 5;
    runTraffic();
    // Expiry cycle and the Idle cycle separate the two packets.
    if (gotCycle.size() > 3 && gotCycle[3] - gotCycle[2] < 3)
    begin
      $display("No Idle cycle between the two North packets");
      errorCount++;
    end
  endtask

  task automatic fullInputDrops();
    clearTraffic();
    firstLen[nocPkg::PortNorth] = 20; // Long grant while East fills.
    firstLen[nocPkg::PortEast]  = FifoDepth + 3;
    fork
      begin
        sendPackets();
        if (inFull[nocPkg::PortEast] !== 1'b1)
        begin
          $display("ERROR inFull[East]: expected 0x1, got 0x%0h", inFull[nocPkg::PortEast]);
          errorCount++;
        end
      end
      collectOutputs(20 + FifoDepth);
    join
    sentCount[nocPkg::PortEast] = FifoDepth; // Later writes were dropped.
    buildExpected();
    compareStream();
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    inValid    = '0;
    inData     = '0;
    seed       = 32'h9cf8ac5a;
    errorCount = 0;
    for (int p = 0; p < NumPorts; p++)
      inFlitId[p] = nocPkg::FlitBody;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    idleAfterReset();
    singlePacket();
    twoPortContention();
    allPortRotation();
    backToBackPackets();
    fullInputDrops();

    $display("Checks finished with %0d errors", errorCount);
    if (errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
